//--- sim/stream_buffer_input.txt
# phase words seed_offset ready_pct
# phase 2 sends full_thresh + 2, two words sit in the read stages
# phase 4 words is the offer limit, the fill stops at in_ready low
1 0 0 100
2 16 3 100
3 3 7 100
4 40 11 100
5 40 21 50
5 64 33 25
5 30 45 90
5 50 57 70
1 0 0 100

//--- stream_buffer.f
common/stream_pkg.sv
common/buffer_cfg_pkg.sv
hdl/counter.sv
axis_fifo/axis_fifo.sv
hdl/burst_ctrl.sv
hdl/stream_buffer_top.sv
sim/stream_buffer_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module stream_buffer_tb -f stream_buffer.f -o sim_stream_buffer

./obj_dir/sim_stream_buffer > sim.log 2>&1
cat sim.log

if grep -q "Simulation FAILED" sim.log; then
  exit 1
fi
exit 0

//--- sim/stream_buffer_tb.sv
`timescale 1ns/1ps

module stream_buffer_tb import stream_pkg::*, buffer_cfg_pkg::*; ();

  logic         clk;
  logic         rst;
  logic         in_valid;
  logic         in_ready;
  stream_word_t in_data;
  logic         out_valid;
  logic         out_ready;
  stream_word_t out_data;
  logic         full;
  logic         empty;

  // words accepted but not yet seen at the output
  stream_word_t ref_q[$];
  int           errors;
  int           timeouts;
  string        test_name;

  // record fields
  string line;
  int    fd;
  int    phase;
  int    count;
  int    seed_off;
  int    ready_pct;

  stream_buffer_top stream_buffer_top_inst (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_data   (in_data),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_data),
    .full      (full),
    .empty     (empty)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      errors++;
      $display("[FAIL] %s expected %0h actual %0h", name, expected, actual);
    end
  endtask

  task automatic report_timeout(input string what);
    timeouts++;
    $display("timeout in %s: %s", test_name, what);
  endtask

  // random data shifted by the record's offset, random last marker
  function automatic stream_word_t make_word(input int off);
    stream_word_t w;
    w.data = 8'($urandom) + 8'(off);
    w.last = 1'($urandom);
    return w;
  endfunction

  task automatic apply_reset();
    @(negedge clk);
    rst       = 1'b1;
    in_valid  = 1'b0;
    out_ready = 1'b0;
    ref_q.delete();
    repeat (2) @(negedge clk);
    rst = 1'b0;
  endtask

  // output side of the model, every handshake pops one expected word
  always @(posedge clk) begin : out_monitor
    stream_word_t exp_w;
    if (!rst && out_valid && out_ready) begin
      if (ref_q.size() == 0) begin
        errors++;
        $display("%s: output word with nothing left in the reference queue", test_name);
      end else begin
        exp_w = ref_q.pop_front();
        check_value({test_name, ".data"}, exp_w.data, out_data.data);
        check_value({test_name, ".last"}, exp_w.last, out_data.last);
      end
    end
  end

  ////////////////////////////////////////
  // stimulus tasks
  ////////////////////////////////////////

  // n words back-to-back, out_ready random at pct
  // returns right after the edge that took the last word
  task automatic stream_words(input int n, input int off, input int pct);
    int           sent;
    int           cycles;
    stream_word_t w;
    sent   = 0;
    cycles = 0;
    w      = make_word(off);
    while (sent < n && cycles < n * 50 + 200) begin
      @(negedge clk);
      out_ready = ($urandom % 100) < pct;
      in_valid  = 1'b1;
      in_data   = w;
      @(posedge clk);
      cycles++;
      if (in_ready) begin
        ref_q.push_back(w);
        sent++;
        w = make_word(off);
      end
    end
    if (sent < n) report_timeout("input side stopped accepting words");
  endtask

  // run the output until the model is empty, then let the fsm close
  // queue is looked at on the falling edge, after the monitor's pop
  task automatic wait_drained(input int pct, input int limit);
    int cycles;
    cycles = 0;
    @(negedge clk);
    in_valid = 1'b0;
    while (ref_q.size() != 0 && cycles < limit) begin
      out_ready = ($urandom % 100) < pct;
      @(negedge clk);
      cycles++;
    end
    if (ref_q.size() != 0) report_timeout("words still missing at the output");
    repeat (3) @(negedge clk);
    check_value({test_name, ".empty"}, 1, empty);
    check_value({test_name, ".idle_valid"}, 0, out_valid);
  endtask

  task automatic wait_out_valid(input int limit);
    int cycles;
    cycles = 0;
    while (!out_valid && cycles < limit) begin
      @(negedge clk);
      in_valid = 1'b0;
      @(posedge clk);
      cycles++;
    end
    if (!out_valid) report_timeout("output never opened");
  endtask

  // fill with the output stalled until in_ready drops
  task automatic capacity_fill(input int limit, input int off);
    int           accepted;
    int           cycles;
    bit           stopped;
    stream_word_t w;
    accepted = 0;
    cycles   = 0;
    stopped  = 1'b0;
    w        = make_word(off);
    while (!stopped && cycles < limit) begin
      @(negedge clk);
      out_ready = 1'b0;
      if (!in_ready) begin
        stopped  = 1'b1;
        in_valid = 1'b0;
      end else begin
        in_valid = 1'b1;
        in_data  = w;
        @(posedge clk);
        cycles++;
        if (in_ready) begin
          ref_q.push_back(w);
          accepted++;
          w = make_word(off);
        end
      end
    end
    if (!stopped) report_timeout("in_ready never fell");
    // memory plus read stage plus output reg
    check_value({test_name, ".accepted"}, fifo_depth + 2, accepted);
    check_value({test_name, ".full"}, 1, full);
  endtask

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////

  initial begin
    void'($urandom(79));
    rst       = 1'b1;
    in_valid  = 1'b0;
    in_data   = '0;
    out_ready = 1'b0;
    errors    = 0;
    timeouts  = 0;
    test_name = "startup";
    apply_reset();
    fd = $fopen("sim/stream_buffer_input.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("could not open the stimulus file sim/stream_buffer_input.txt");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        // skip blank and comment lines
        if (line.len() > 1 && line[0] != "#" &&
            $sscanf(line, "%d %d %d %d", phase, count, seed_off, ready_pct) == 4) begin
          case (phase)
            1: begin
              test_name = "reset_state";
              apply_reset();
              check_value("reset_state.out_valid", 0, out_valid);
              check_value("reset_state.in_ready", 1, in_ready);
              check_value("reset_state.full", 0, full);
              check_value("reset_state.empty", 1, empty);
            end
            2: begin
              test_name = "threshold_drain";
              stream_words(count, seed_off, ready_pct);
              // well short of the idle timeout
              wait_out_valid(flush_timeout / 2);
              wait_drained(ready_pct, 1000);
            end
            3: begin
              test_name = "timeout_flush";
              stream_words(count, seed_off, ready_pct);
              @(negedge clk);
              in_valid = 1'b0;
              repeat (flush_timeout - 1) begin
                @(posedge clk);
                check_value("timeout_flush.early_valid", 0, out_valid);
              end
              wait_drained(ready_pct, 1000);
            end
            4: begin
              test_name = "capacity";
              capacity_fill(count, seed_off);
              wait_drained(ready_pct, 1000);
            end
            5: begin
              test_name = "random_backpressure";
              stream_words(count, seed_off, ready_pct);
              wait_drained(ready_pct, 5000);
            end
            default: begin
              errors++;
              $display("unknown phase %0d in the stimulus file", phase);
            end
          endcase
        end
      end
      $fclose(fd);
    end
    $display("errors: %0d mismatches, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

//--- hdl/stream_buffer_top.sv
`timescale 1ns/1ps

module stream_buffer_top import buffer_cfg_pkg::*, stream_pkg::*; (
  input  logic         clk,
  input  logic         rst,
  // input stream
  input  logic         in_valid,
  output logic         in_ready,
  input  stream_word_t in_data,
  // output stream
  output logic         out_valid,
  input  logic         out_ready,
  output stream_word_t out_data,
  // status
  output logic         full,
  output logic         empty
);

  ////////////////////////////////////////
  // fifo to controller
  ////////////////////////////////////////

  logic fifo_valid;
  logic fifo_ready;
  logic wr_accept;
  logic drained;

  // buffer, data goes straight out, valid/ready via the controller
  // full doubles as the controller's almost_full
  axis_fifo #(
    .payload_t (stream_word_t)
  ) axis_fifo_inst (
    .clk         (clk),
    .rst         (rst),
    .in_valid    (in_valid),
    .in_ready    (in_ready),
    .in_data     (in_data),
    .fifo_valid  (fifo_valid),
    .fifo_ready  (fifo_ready),
    .fifo_data   (out_data),
    .wr_accept   (wr_accept),
    .almost_full (full),
    .empty_flag  (empty),
    .drained     (drained)
  );

  // output gate
  burst_ctrl burst_ctrl_inst (
    .clk         (clk),
    .rst         (rst),
    .wr_accept   (wr_accept),
    .almost_full (full),
    .drained     (drained),
    .fifo_valid  (fifo_valid),
    .fifo_ready  (fifo_ready),
    .out_valid   (out_valid),
    .out_ready   (out_ready)
  );

endmodule

//--- hdl/burst_ctrl.sv
`timescale 1ns/1ps

module burst_ctrl import buffer_cfg_pkg::*; (
  input  logic clk,
  input  logic rst,
  // fifo status
  input  logic wr_accept,
  input  logic almost_full,
  input  logic drained,
  // fifo read side
  input  logic fifo_valid,
  output logic fifo_ready,
  // gated output stream
  output logic out_valid,
  input  logic out_ready
);

  typedef enum logic {
    st_idle,
    st_drain
  } state_t;

  state_t state;
  state_t state_next;

  // output gate open
  logic draining;

  // idle timer
  logic timer_clr;
  logic timer_ena;
  logic timer_expired;

  assign draining = (state == st_drain);

  ////////////////////////////////////////
  // idle flush timer
  ////////////////////////////////////////

  // restarts on every accepted word
  // also parked while draining so a stale expiry never reopens the gate
  assign timer_clr = wr_accept | draining;

  // runs only while words wait behind the closed gate
  assign timer_ena = ~draining & ~drained;

  // starts at 1 so expiry lands flush_timeout edges after the accept
  counter #(
    .lower      (1),
    .upper      (flush_timeout),
    .wraparound (1'b0)
  ) idle_timer_cnt (
    .clk      (clk),
    .rst      (rst),
    .clr      (timer_clr),
    .ena      (timer_ena),
    .value    (),
    .at_upper (timer_expired)
  );

  ////////////////////////////////////////
  // idle / drain fsm
  ////////////////////////////////////////

  always_comb begin
    state_next = state;
    case (state)
      st_idle: begin
        // threshold or timeout with something waiting
        if (almost_full || (timer_expired && !drained)) begin
          state_next = st_drain;
        end
      end
      st_drain: begin
        // empty all the way, close again
        if (drained) begin
          state_next = st_idle;
        end
      end
      default: state_next = st_idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= st_idle;
    end else begin
      state <= state_next;
    end
  end

  // handshake passes only while draining
  assign out_valid  = fifo_valid & draining;
  assign fifo_ready = out_ready & draining;

  ////////////////////////////////////////
  // checks
  ////////////////////////////////////////

  // gate closes with no word held at the output, so out_valid stays low in idle
  a_closed_when_idle : assert property (
    @(posedge clk) disable iff (rst)
    $fell(draining) |-> !fifo_valid
  );

endmodule

//--- axis_fifo/axis_fifo.sv
`timescale 1ns/1ps

module axis_fifo import buffer_cfg_pkg::*, stream_pkg::*; #(
  parameter type payload_t = stream_word_t
) (
  input  logic     clk,
  input  logic     rst,
  // write side
  input  logic     in_valid,
  output logic     in_ready,
  input  payload_t in_data,
  // read side
  output logic     fifo_valid,
  input  logic     fifo_ready,
  output payload_t fifo_data,
  // status
  output logic     wr_accept,
  output logic     almost_full,
  output logic     empty_flag,
  output logic     drained
);

  // storage, no reset on payload
  payload_t mem [fifo_depth];

  // pointers and fold flags
  logic [addr_width-1:0] wr_addr;
  logic [addr_width-1:0] rd_addr;
  logic                  wr_at_top;
  logic                  rd_at_top;
  logic                  wr_fold;
  logic                  rd_fold;

  // memory status from pointer compare
  logic                  mem_full;
  logic                  mem_empty;

  // handshake strobes
  logic                  wr_ena;
  logic                  rd_ena;
  logic                  handoff;
  logic                  advance;

  // read stage between memory and output reg
  payload_t              stage_data;
  logic                  stage_valid;

  // words held in memory only, 0 to fifo_depth
  logic [addr_width:0]   count;

  ////////////////////////////////////////
  // handshakes
  ////////////////////////////////////////

  assign in_ready  = ~mem_full;
  assign wr_ena    = in_valid & in_ready;
  assign wr_accept = wr_ena;

  // output reg empty or being taken this cycle
  assign handoff = fifo_valid & fifo_ready;
  assign advance = ~fifo_valid | handoff;

  // pop memory only when the pipe moves
  assign rd_ena = advance & ~mem_empty;

  ////////////////////////////////////////
  // write pointer and memory
  ////////////////////////////////////////

  counter #(
    .lower      (0),
    .upper      (fifo_depth - 1),
    .wraparound (1'b1)
  ) wr_ptr_cnt (
    .clk      (clk),
    .rst      (rst),
    .clr      (1'b0),
    .ena      (wr_ena),
    .value    (wr_addr),
    .at_upper (wr_at_top)
  );

  // flips each time the write pointer wraps
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_fold <= 1'b0;
    end else if (wr_ena && wr_at_top) begin
      wr_fold <= ~wr_fold;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_ena) begin
      mem[wr_addr] <= in_data;
    end
  end

  ////////////////////////////////////////
  // read pointer and read path
  ////////////////////////////////////////

  counter #(
    .lower      (0),
    .upper      (fifo_depth - 1),
    .wraparound (1'b1)
  ) rd_ptr_cnt (
    .clk      (clk),
    .rst      (rst),
    .clr      (1'b0),
    .ena      (rd_ena),
    .value    (rd_addr),
    .at_upper (rd_at_top)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_fold <= 1'b0;
    end else if (rd_ena && rd_at_top) begin
      rd_fold <= ~rd_fold;
    end
  end

  // stage 1, registered memory read
  always_ff @(posedge clk) begin
    if (rd_ena) begin
      stage_data <= mem[rd_addr];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      stage_valid <= 1'b0;
    end else if (advance) begin
      stage_valid <= ~mem_empty;
    end
  end

  // stage 2, output reg, holds under back-pressure
  always_ff @(posedge clk) begin
    if (rst) begin
      fifo_valid <= 1'b0;
    end else if (advance) begin
      fifo_valid <= stage_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (advance && stage_valid) begin
      fifo_data <= stage_data;
    end
  end

  ////////////////////////////////////////
  // status
  ////////////////////////////////////////

  // same address, different fold -> writer is a lap ahead
  assign mem_full  = (wr_addr == rd_addr) && (wr_fold != rd_fold);
  // same address, same fold -> nothing stored
  assign mem_empty = (wr_addr == rd_addr) && (wr_fold == rd_fold);

  // occupancy for the soft thresholds
  always_ff @(posedge clk) begin
    if (rst) begin
      count <= '0;
    end else begin
      case ({wr_ena, rd_ena})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  assign almost_full = (count >= full_thresh);
  assign empty_flag  = (count <= empty_thresh);

  // nothing anywhere, memory and both stages
  assign drained = mem_empty & ~stage_valid & ~fifo_valid;

  ////////////////////////////////////////
  // checks
  ////////////////////////////////////////

  // occupancy count agrees with the fold-flag full detect
  a_no_write_when_full : assert property (
    @(posedge clk) disable iff (rst)
    wr_accept |-> (count < fifo_depth)
  );

  // stalled word stays put until taken
  a_hold_under_stall : assert property (
    @(posedge clk) disable iff (rst)
    (fifo_valid && !fifo_ready) |=> (fifo_valid && $stable(fifo_data))
  );

endmodule

//--- hdl/counter.sv
`timescale 1ns/1ps

module counter import buffer_cfg_pkg::*; #(
  // first value after reset or clear
  parameter int lower = 0,
  // last value before wrap or hold
  parameter int upper = fifo_depth - 1,
  // 1 wraps back to lower, 0 sticks at upper
  parameter bit wraparound = 1'b1
) (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           clr,
  input  logic                           ena,
  output logic [$clog2(upper + 1) - 1:0] value,
  output logic                           at_upper
);

  // width of the value register
  localparam int width = $clog2(upper + 1);

  ////////////////////////////////////////
  // count register
  ////////////////////////////////////////

  // top reached, owner uses it for fold flags or expiry
  assign at_upper = (value == width'(upper));

  always_ff @(posedge clk) begin
    if (rst || clr) begin
      value <= width'(lower);
    end else if (ena) begin
      if (!at_upper) begin
        value <= value + 1'b1;
      end else if (wraparound) begin
        value <= width'(lower);
      end
    end
  end

  ////////////////////////////////////////
  // checks
  ////////////////////////////////////////

  // range holds over any mix of clear, enable and wrap
  a_value_in_range : assert property (
    @(posedge clk) disable iff (rst)
    (value >= width'(lower)) && (value <= width'(upper))
  );

endmodule

//--- common/buffer_cfg_pkg.sv
package buffer_cfg_pkg;

  ////////////////////////////////////////
  // fifo geometry
  ////////////////////////////////////////

  // memory entries, read stage and output reg come on top
  localparam int fifo_depth = 16;

  // pointer width, log2 of the depth
  localparam int addr_width = 4;

  ////////////////////////////////////////
  // status thresholds
  ////////////////////////////////////////

  // stored words at or above this raise full
  localparam int full_thresh = 14;

  // stored words at or below this raise empty
  localparam int empty_thresh = 2;

  ////////////////////////////////////////
  // burst control
  ////////////////////////////////////////

  // idle cycles before waiting words are pushed out anyway
  localparam int flush_timeout = 20;

  // wide enough to hold flush_timeout
  localparam int timer_width = 5;

endpackage

//--- common/stream_pkg.sv
package stream_pkg;

  ////////////////////////////////////////
  // payload format
  ////////////////////////////////////////

  // width of the data field
  localparam int data_width = 8;

  // one word on the stream
  // last rides along with the data, nothing in the buffer looks at it
  typedef struct packed {
    logic [data_width-1:0] data;
    logic                  last;
  } stream_word_t;

endpackage
